// ==== rv_int_pkg.sv ====
//##########################################################################
// RV64 integer cluster shared types: widths, opcodes, instruction views,
// micro-op and writeback records.
//##########################################################################
package rv_int_pkg;

	localparam int xlen = 64;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] xword_t;

	localparam logic [6:0] opc_op     = 7'b0110011; // R-type, also MUL.
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_view_t;

	// Same word, two field layouts.
	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} instr_u;

	typedef enum logic [3:0] {add, sub, and_, or_, xor_, sll, srl, slt, pass_b} alu_op_e;

	typedef struct packed {
		logic      valid;
		alu_op_e   op;
		reg_addr_t rd;
		xword_t    a;
		xword_t    b;
	} alu_uop_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		xword_t    a;
		xword_t    b;
	} mul_uop_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		xword_t    data;
	} wb_req_t;

	// Destination tag of one mul stage.
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
	} mul_tag_t;

endpackage

// ==== regfile.sv ====
//##########################################################################
// Register file, 32 x 64 bits, x0 fixed at zero.
// Two operand ports and a debug port, each with write bypass.
//##########################################################################
`timescale 1ns/1ps

module regfile (
	input  logic                  clk,
	input  logic                  reset,
	input  rv_int_pkg::wb_req_t   wr,
	input  rv_int_pkg::reg_addr_t raddr1,
	input  rv_int_pkg::reg_addr_t raddr2,
	input  logic                  re1,
	input  logic                  re2,
	output rv_int_pkg::xword_t    rdata1,
	output rv_int_pkg::xword_t    rdata2,
	input  logic                  dbg_en,
	input  rv_int_pkg::reg_addr_t dbg_addr,
	output rv_int_pkg::xword_t    dbg_data
);
	import rv_int_pkg::*;

	xword_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// Write data wins on an address match.
	function automatic xword_t read_port(input logic en, input reg_addr_t addr,
			input wb_req_t w, input xword_t stored);
		if (!en)
			return '0;
		if (w.valid && w.rd == addr)
			return w.data;
		return stored;
	endfunction

	assign rdata1   = read_port(re1, raddr1, wr, regs[raddr1]);
	assign rdata2   = read_port(re2, raddr2, wr, regs[raddr2]);
	assign dbg_data = read_port(dbg_en, dbg_addr, wr, regs[dbg_addr]); // Observation only.

endmodule

// ==== issue_ctrl.sv ====
//##########################################################################
// Issue stage: decodes the instruction, checks the mul scoreboard,
// raises busy and illegal, and dispatches ALU or MUL micro-ops.
//##########################################################################
`timescale 1ns/1ps

module issue_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instr_valid,
	input  rv_int_pkg::instr_u         instr,
	output rv_int_pkg::reg_addr_t      raddr1,
	output rv_int_pkg::reg_addr_t      raddr2,
	output logic                       re1,
	output logic                       re2,
	input  rv_int_pkg::xword_t         rdata1,
	input  rv_int_pkg::xword_t         rdata2,
	input  logic                       alu_hold,
	input  rv_int_pkg::mul_tag_t [2:0] pending,
	output rv_int_pkg::alu_uop_t       alu_uop,
	output rv_int_pkg::mul_uop_t       mul_uop,
	output logic                       busy,
	output logic                       illegal
);
	import rv_int_pkg::*;

	logic [6:0] opcode;
	logic       is_r;
	logic       is_i;
	logic       is_lui;
	logic       is_mul;
	logic       legal;
	alu_op_e    op;
	xword_t     imm_i;
	xword_t     imm_u;
	logic       sb_match;
	logic       mul_active;
	logic       alu_live;   // ALU result register is valid this cycle.
	logic       accept;

	assign opcode = instr.r_view.opcode;
	assign is_r   = (opcode == opc_op);
	assign is_i   = (opcode == opc_op_imm);
	assign is_lui = (opcode == opc_lui);

	assign imm_i = {{52{instr.i_view.imm12[11]}}, instr.i_view.imm12};
	// U immediate is the top 20 bits of the I layout.
	assign imm_u = {{32{instr.i_view.imm12[11]}}, instr.i_view.imm12, instr.i_view.rs1,
			instr.i_view.funct3, 12'd0};

	always_comb begin
		op     = add;
		legal  = 1'b0;
		is_mul = 1'b0;
		if (is_r) begin
			legal = 1'b1;
			case ({instr.r_view.funct7, instr.r_view.funct3})
				10'b0000000_000: op = add;
				10'b0100000_000: op = sub;
				10'b0000000_111: op = and_;
				10'b0000000_110: op = or_;
				10'b0000000_100: op = xor_;
				10'b0000000_001: op = sll;
				10'b0000000_101: op = srl;
				10'b0000000_010: op = slt;
				10'b0000001_000: is_mul = 1'b1;
				default:         legal = 1'b0;
			endcase
		end else if (is_i) begin
			legal = 1'b1;
			case (instr.i_view.funct3)
				3'b000:  op = add;
				3'b111:  op = and_;
				3'b110:  op = or_;
				3'b100:  op = xor_;
				default: legal = 1'b0;
			endcase
		end else if (is_lui) begin
			legal = 1'b1;
			op    = pass_b;
		end
	end

	assign raddr1 = instr.r_view.rs1;
	assign raddr2 = instr.r_view.rs2;
	assign re1    = is_r | is_i;
	assign re2    = is_r;           // Only R-type reads rs2.

	// Any live mul stage that this instruction reads or overwrites.
	always_comb begin
		sb_match   = 1'b0;
		mul_active = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (pending[i].valid) begin
				mul_active = 1'b1;
				if (pending[i].rd != '0 && ((re1 && pending[i].rd == raddr1) ||
						(re2 && pending[i].rd == raddr2) ||
						pending[i].rd == instr.r_view.rd))
					sb_match = 1'b1;
			end
		end
	end

	assign busy   = alu_hold | (mul_active & alu_live) | sb_match;
	assign accept = instr_valid & ~busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			alu_live <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			alu_live <= alu_uop.valid | alu_hold;
			illegal  <= accept & ~legal;
		end
	end

	assign alu_uop.valid = accept & legal & ~is_mul;
	assign alu_uop.op    = op;
	assign alu_uop.rd    = instr.r_view.rd;
	assign alu_uop.a     = rdata1;
	assign alu_uop.b     = is_r ? rdata2 : (is_lui ? imm_u : imm_i);

	assign mul_uop.valid = accept & is_mul;
	assign mul_uop.rd    = instr.r_view.rd;
	assign mul_uop.a     = rdata1;
	assign mul_uop.b     = rdata2;

endmodule

// ==== alu_unit.sv ====
//##########################################################################
// Single-cycle ALU with a result register held until writeback is granted.
//##########################################################################
`timescale 1ns/1ps

module alu_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  rv_int_pkg::alu_uop_t uop,
	input  logic                 grant,
	output rv_int_pkg::wb_req_t  wb,
	output logic                 hold
);
	import rv_int_pkg::*;

	xword_t    result;
	logic      valid_q;
	reg_addr_t rd_q;
	xword_t    data_q;

	always_comb begin
		case (uop.op)
			add:     result = uop.a + uop.b;
			sub:     result = uop.a - uop.b;
			and_:    result = uop.a & uop.b;
			or_:     result = uop.a | uop.b;
			xor_:    result = uop.a ^ uop.b;
			sll:     result = uop.a << uop.b[5:0];
			srl:     result = uop.a >> uop.b[5:0];
			slt:     result = {63'd0, $signed(uop.a) < $signed(uop.b)};
			pass_b:  result = uop.b;    // LUI.
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else if (uop.valid)
			valid_q <= 1'b1;
		else if (grant)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (uop.valid) begin
			rd_q   <= uop.rd;
			data_q <= result;
		end
	end

	assign wb   = '{valid: valid_q, rd: rd_q, data: data_q};
	assign hold = valid_q & ~grant; // Mul owns the port.

endmodule

// ==== mul_pipe.sv ====
//##########################################################################
// Three-stage 64-bit multiplier, low product, up to three ops in flight.
//##########################################################################
`timescale 1ns/1ps

module mul_pipe (
	input  logic                       clk,
	input  logic                       reset,
	input  rv_int_pkg::mul_uop_t       uop,
	output rv_int_pkg::wb_req_t        wb,
	output rv_int_pkg::mul_tag_t [2:0] pending
);
	import rv_int_pkg::*;

	mul_tag_t    s1_tag;
	mul_tag_t    s2_tag;
	mul_tag_t    s3_tag;
	xword_t      s1_a;
	xword_t      s1_b;
	logic [63:0] s2_ll;     // Low x low, full width.
	logic [31:0] s2_lh;
	logic [31:0] s2_hl;
	xword_t      s3_prod;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_tag.valid <= 1'b0;
			s2_tag.valid <= 1'b0;
			s3_tag.valid <= 1'b0;
		end else begin
			s1_tag <= '{valid: uop.valid, rd: uop.rd};
			s2_tag <= s1_tag;
			s3_tag <= s2_tag;
		end
	end

	always_ff @(posedge clk) begin
		s1_a    <= uop.a;
		s1_b    <= uop.b;
		s2_ll   <= s1_a[31:0] * s1_b[31:0];
		s2_lh   <= s1_a[31:0] * s1_b[63:32];  // Only the low half reaches bit 63.
		s2_hl   <= s1_a[63:32] * s1_b[31:0];
		s3_prod <= s2_ll + {s2_lh + s2_hl, 32'd0};
	end

	assign wb = '{valid: s3_tag.valid, rd: s3_tag.rd, data: s3_prod};

	assign pending[0] = s1_tag;
	assign pending[1] = s2_tag;
	assign pending[2] = s3_tag;

endmodule

// ==== wb_arbiter.sv ====
//##########################################################################
// Writeback arbiter for the single register write port, mul over ALU.
//##########################################################################
`timescale 1ns/1ps

module wb_arbiter (
	input  rv_int_pkg::wb_req_t mul_wb,
	input  rv_int_pkg::wb_req_t alu_wb,
	output rv_int_pkg::wb_req_t wr,
	output logic                alu_grant
);
	logic mul_req;
	logic alu_req;

	// Results for x0 are dropped here.
	assign mul_req = mul_wb.valid && mul_wb.rd != '0;
	assign alu_req = alu_wb.valid && alu_wb.rd != '0;

	// ALU goes only in a cycle with no mul result.
	assign alu_grant = ~mul_wb.valid;

	always_comb begin
		if (mul_req)
			wr = mul_wb;
		else if (alu_req && alu_grant)
			wr = alu_wb;
		else
			wr = '0;
	end

endmodule

// ==== rv_int_core.sv ====
//##########################################################################
// RV64 integer execute cluster top: issue, ALU, mul pipe, arbiter, regs.
//##########################################################################
`timescale 1ns/1ps

module rv_int_core (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  instr_valid,
	input  rv_int_pkg::instr_u    instr,
	input  logic                  dbg_en,
	input  rv_int_pkg::reg_addr_t dbg_addr,
	output logic                  busy,
	output logic                  illegal,
	output rv_int_pkg::xword_t    dbg_data
);
	import rv_int_pkg::*;

	reg_addr_t      raddr1;
	reg_addr_t      raddr2;
	logic           re1;
	logic           re2;
	xword_t         rdata1;
	xword_t         rdata2;
	alu_uop_t       alu_uop;
	mul_uop_t       mul_uop;
	wb_req_t        alu_wb;
	wb_req_t        mul_wb;
	wb_req_t        wr;        // Arbitrated write port.
	logic           alu_grant;
	logic           alu_hold;
	mul_tag_t [2:0] pending;

	issue_ctrl issue_i (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.raddr1(raddr1), .raddr2(raddr2), .re1(re1), .re2(re2),
		.rdata1(rdata1), .rdata2(rdata2), .alu_hold(alu_hold), .pending(pending),
		.alu_uop(alu_uop), .mul_uop(mul_uop), .busy(busy), .illegal(illegal)
	);

	alu_unit alu_i (
		.clk(clk), .reset(reset), .uop(alu_uop), .grant(alu_grant),
		.wb(alu_wb), .hold(alu_hold)
	);

	mul_pipe mul_i (.clk(clk), .reset(reset), .uop(mul_uop), .wb(mul_wb), .pending(pending));

	wb_arbiter arb_i (.mul_wb(mul_wb), .alu_wb(alu_wb), .wr(wr), .alu_grant(alu_grant));

	regfile regs_i (
		.clk(clk), .reset(reset), .wr(wr),
		.raddr1(raddr1), .raddr2(raddr2), .re1(re1), .re2(re2),
		.rdata1(rdata1), .rdata2(rdata2),
		.dbg_en(dbg_en), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
	);

endmodule

// ==== tb_rv_int_core.sv ====
//##########################################################################
// Testbench for the RV64 integer cluster: random instruction stream,
// reference register model and assertion checks.
//##########################################################################
`timescale 1ns/1ps

module tb_rv_int_core;
	import rv_int_pkg::*;

	localparam int num_random     = 200;
	localparam int num_directed   = 9;
	localparam int timeout_cycles = 4 * (num_random + num_directed + 20);

	logic      clk = 1'b0;
	logic      reset;
	logic      instr_valid;
	instr_u    instr;
	logic      dbg_en;
	reg_addr_t dbg_addr;
	logic      busy;
	logic      illegal;
	xword_t    dbg_data;

	xword_t    model [32];      // Architectural register state in program order.
	integer    seed = 32'h70c6;
	int        cycle_count = 0;
	logic      illegal_exp;     // Illegal pulse due in this cycle.
	logic      stall_exp;
	logic      idle_exp;
	logic      read_check;
	xword_t    read_exp;

	rv_int_core dut_i (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.dbg_en(dbg_en), .dbg_addr(dbg_addr),
		.busy(busy), .illegal(illegal), .dbg_data(dbg_data)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles: the core never drained", cycle_count);
			$display("Simulation FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// Sampled on the falling edge, where inputs and outputs are settled.
	idle_after_reset: assert property (@(negedge clk) disable iff (reset)
		idle_exp |-> (!busy && !illegal))
		else report_failure("busy or illegal high after reset");

	illegal_pulse: assert property (@(negedge clk) disable iff (reset) illegal == illegal_exp)
		else report_failure($sformatf("illegal is %0b, expected %0b", illegal, illegal_exp));

	mul_hazard_stall: assert property (@(negedge clk) disable iff (reset) stall_exp |-> busy)
		else report_failure("no busy on a read of a pending mul destination");

	reg_contents: assert property (@(negedge clk) disable iff (reset)
		read_check |-> dbg_data == read_exp)
		else report_failure($sformatf("x%0d reads %h, expected %h", dbg_addr, dbg_data, read_exp));

	dbg_quiet: assert property (@(negedge clk) !dbg_en |-> dbg_data == '0)
		else report_failure($sformatf("dbg_data is %h with dbg_en low", dbg_data));

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
			input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, opc_op};
	endfunction

	function automatic logic [31:0] i_type(input logic [2:0] f3, input reg_addr_t rd,
			input reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc_op_imm};
	endfunction

	function automatic logic [31:0] u_type(input reg_addr_t rd, input logic [19:0] imm);
		return {imm, rd, opc_lui};
	endfunction

	// Only x0..x7, so hazards come up often.
	function automatic logic [31:0] random_instr();
		logic [9:0]  alu_codes [8] = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
				10'b0000000_110, 10'b0000000_100, 10'b0000000_001, 10'b0000000_101,
				10'b0000000_010};
		logic [2:0]  imm_codes [4] = '{3'b000, 3'b111, 3'b110, 3'b100};
		logic [31:0] r;
		int          kind;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [9:0]  f;
		r    = $random(seed);
		kind = $unsigned($random(seed)) % 20;
		rd   = {2'b00, r[2:0]};
		rs1  = {2'b00, r[5:3]};
		rs2  = {2'b00, r[8:6]};
		f    = alu_codes[r[11:9]];
		case (kind)
			6, 7, 8, 9:     return i_type(imm_codes[r[13:12]], rd, rs1, r[31:20]);
			10, 11:         return u_type(rd, r[31:12]);
			12, 13, 14, 15: return r_type(7'b0000001, 3'b000, rd, rs1, rs2);
			16:             return {r[31:12], rd, 7'b0000011};  // Load, unsupported.
			17:             return i_type(3'b001, rd, rs1, r[31:20]); // Shift immediate.
			default:        return r_type(f[9:3], f[2:0], rd, rs1, rs2);
		endcase
	endfunction

	// Executes one instruction on the model, straight from the ISA rules.
	task automatic apply_model(input logic [31:0] w, output logic legal);
		xword_t a;
		xword_t b;
		xword_t imm;
		xword_t res;
		a     = model[w[19:15]];
		b     = model[w[24:20]];
		imm   = {{52{w[31]}}, w[31:20]};
		res   = '0;
		legal = 1'b1;
		case (w[6:0])
			opc_op: begin
				case ({w[31:25], w[14:12]})
					10'b0000000_000: res = a + b;
					10'b0100000_000: res = a - b;
					10'b0000000_111: res = a & b;
					10'b0000000_110: res = a | b;
					10'b0000000_100: res = a ^ b;
					10'b0000000_001: res = a << b[5:0];
					10'b0000000_101: res = a >> b[5:0];
					10'b0000000_010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					10'b0000001_000: res = a * b;   // Low 64 bits only.
					default:         legal = 1'b0;
				endcase
			end
			opc_op_imm: begin
				case (w[14:12])
					3'b000:  res = a + imm;
					3'b111:  res = a & imm;
					3'b110:  res = a | imm;
					3'b100:  res = a ^ imm;
					default: legal = 1'b0;
				endcase
			end
			opc_lui: res = {{32{w[31]}}, w[31:12], 12'h000};
			default: legal = 1'b0;
		endcase
		if (legal && w[11:7] != 5'd0)
			model[w[11:7]] = res;
	endtask

	// Entered 2 ns after a rising edge; strobes only once busy is low.
	task automatic issue_instr(input logic [31:0] w, input logic want_stall);
		logic legal;
		instr     = w;
		stall_exp = want_stall;
		dbg_addr  = w[11:7];
		#1;
		while (busy) begin
			@(posedge clk);
			#2;
			illegal_exp = 1'b0;
			stall_exp   = 1'b0;
			#1;
		end
		instr_valid = 1'b1;
		apply_model(w, legal);
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
		stall_exp   = 1'b0;
		illegal_exp = !legal;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2;
		illegal_exp = 1'b0;
	endtask

	task automatic read_all_regs();
		for (int i = 0; i < 32; i++) begin
			dbg_en     = 1'b1;
			dbg_addr   = reg_addr_t'(i);
			read_exp   = model[i];
			read_check = 1'b1;
			@(posedge clk);
			#2;
		end
		read_check = 1'b0;
		dbg_en     = 1'b0;
	endtask

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		dbg_en      = 1'b0;
		dbg_addr    = '0;
		illegal_exp = 1'b0;
		stall_exp   = 1'b0;
		idle_exp    = 1'b0;
		read_check  = 1'b0;
		read_exp    = '0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		repeat (3) @(posedge clk);
		#2;
		reset    = 1'b0;
		idle_exp = 1'b1;
		read_all_regs();    // Everything zero out of reset.
		idle_exp = 1'b0;

		issue_instr(i_type(3'b000, 5'd2, 5'd0, 12'h5a5), 1'b0);
		issue_instr(u_type(5'd3, 20'hfedcb), 1'b0);
		issue_instr(i_type(3'b110, 5'd3, 5'd3, 12'h321), 1'b0);
		// Independent multiplies, back to back.
		issue_instr(r_type(7'b0000001, 3'b000, 5'd1, 5'd2, 5'd3), 1'b0);
		issue_instr(r_type(7'b0000001, 3'b000, 5'd4, 5'd3, 5'd3), 1'b0);
		issue_instr(r_type(7'b0000001, 3'b000, 5'd5, 5'd2, 5'd2), 1'b0);
		issue_instr(r_type(7'b0000001, 3'b000, 5'd6, 5'd2, 5'd3), 1'b0);
		issue_instr(r_type(7'b0000000, 3'b000, 5'd7, 5'd6, 5'd2), 1'b1); // Needs x6.
		issue_instr(32'h0000_3083, 1'b0);   // Load opcode aimed at x1.

		for (int n = 0; n < num_random; n++)
			issue_instr(random_instr(), 1'b0);

		instr = '0;
		idle_cycle();
		while (busy)
			idle_cycle();
		repeat (4) idle_cycle();
		read_all_regs();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== rv_int_core.f ====
rv_int_pkg.sv
regfile.sv
issue_ctrl.sv
alu_unit.sv
mul_pipe.sv
wb_arbiter.sv
rv_int_core.sv
tb_rv_int_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the rv_int_core testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_rv_int_core -f rv_int_core.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_rv_int_core)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q "^Simulation PASSED$"; then
	exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
